/* sfm_macros.svh */
`ifndef SFM_MACROS_SVH
`define SFM_MACROS_SVH

// --------------------------------------------------
// memory word and address geometry
// --------------------------------------------------

// bits per scratch memory word
`define SFM_DATA_WIDTH 32

// bits of a byte address
`define SFM_ADDR_WIDTH 32

// --------------------------------------------------
// load side sizing
// --------------------------------------------------

// cycles from a granted read to its rvalid
`define SFM_READ_LATENCY 1

// words the load unit may have requested or buffered but not yet handed on
`define SFM_LOAD_DEPTH 2

`endif

/* sfm_pkg.sv */
`include "sfm_macros.svh"

package sfm_pkg;

    // --------------------------------------------------
    // data path vectors
    // --------------------------------------------------

    typedef logic [`SFM_DATA_WIDTH-1:0]   sfm_word_t;
    typedef logic [`SFM_DATA_WIDTH/8-1:0] sfm_strb_t;   // one bit per byte lane
    typedef logic [`SFM_ADDR_WIDTH-1:0]   sfm_addr_t;

    // --------------------------------------------------
    // job description
    // --------------------------------------------------

    typedef logic [15:0] sfm_len_t;         // length in bytes
    typedef logic [14:0] sfm_beat_cnt_t;    // enough for a full-length job rounded up

    // job decoder states
    typedef enum logic [1:0] {
        IDLE,
        RUN,
        FINISH
    } sfm_job_state_e;

endpackage

/* sfm_job_decode.sv */
`timescale 1ns/1ps

module sfm_job_decode (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   clear_i,
    input  logic                   start_i,
    input  sfm_pkg::sfm_addr_t     src_addr_i,
    input  sfm_pkg::sfm_addr_t     dst_addr_i,
    input  sfm_pkg::sfm_len_t      len_i,
    input  logic                   store_done_i,
    output logic                   go_o,
    output sfm_pkg::sfm_addr_t     src_base_o,
    output sfm_pkg::sfm_addr_t     dst_base_o,
    output sfm_pkg::sfm_beat_cnt_t beats_o,
    output sfm_pkg::sfm_strb_t     final_strb_o,
    output logic                   busy_o,
    output logic                   done_o
);

    import sfm_pkg::*;

    sfm_job_state_e state_q, state_d;
    logic           accept;
    logic           go_q;
    logic [1:0]     lftovr;
    sfm_beat_cnt_t  beats_d;
    sfm_strb_t      final_strb_d;

    // a start in FINISH is taken, only RUN counts as busy
    assign accept = start_i && (state_q != RUN);

    // --------------------------------------------------
    // beat count and final strobe
    // --------------------------------------------------

    assign lftovr  = len_i[1:0];
    assign beats_d = {1'b0, len_i[15:2]} + {14'd0, |lftovr};   // round up for leftover bytes

    always_comb begin
        final_strb_d = '1;
        for (int i = 0; i < $bits(sfm_strb_t); i++) begin
            if (lftovr != 2'd0 && i >= lftovr) begin
                final_strb_d[i] = 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            src_base_o   <= src_addr_i & ~sfm_addr_t'(3);   // low address bits are ignored
            dst_base_o   <= dst_addr_i & ~sfm_addr_t'(3);
            beats_o      <= beats_d;
            final_strb_o <= final_strb_d;
        end
    end

    // --------------------------------------------------
    // job FSM
    // --------------------------------------------------

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:    if (accept) state_d = RUN;
            RUN:     if (beats_o == '0 || store_done_i) state_d = FINISH;
            FINISH:  state_d = accept ? RUN : IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
            go_q    <= 1'b0;
        end else if (clear_i) begin
            state_q <= IDLE;
            go_q    <= 1'b0;
        end else begin
            state_q <= state_d;
            go_q    <= accept;
        end
    end

    assign go_o   = go_q;
    assign busy_o = (state_q == RUN);
    assign done_o = (state_q == FINISH);

    // go only marks the first cycle of a job, never a job already running
    a_go_on_entry: assert property (@(posedge clk_i) disable iff (!rst_ni)
        go_o |-> busy_o && !$past(busy_o));

endmodule

/* sfm_load_unit.sv */
`timescale 1ns/1ps
`include "sfm_macros.svh"

module sfm_load_unit (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   clear_i,
    input  logic                   go_i,
    input  sfm_pkg::sfm_addr_t     base_i,
    input  sfm_pkg::sfm_beat_cnt_t beats_i,
    input  sfm_pkg::sfm_strb_t     final_strb_i,
    input  logic                   gnt_i,
    input  sfm_pkg::sfm_word_t     rdata_i,
    input  logic                   rvalid_i,
    input  logic                   strm_ready_i,
    output logic                   req_o,
    output sfm_pkg::sfm_addr_t     addr_o,
    output logic                   strm_valid_o,
    output sfm_pkg::sfm_word_t     strm_data_o,
    output sfm_pkg::sfm_strb_t     strm_strb_o
);

    import sfm_pkg::*;

    localparam int unsigned DEPTH = `SFM_LOAD_DEPTH;
    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    logic             active_q;
    sfm_beat_cnt_t    req_cnt_q;
    sfm_beat_cnt_t    out_cnt_q;
    logic [CNT_W-1:0] pend_q;    // reads granted but not yet returned
    logic [CNT_W-1:0] cnt_q;     // words sitting in the FIFO
    logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
    sfm_word_t        fifo_q [DEPTH];
    logic             rd_gnt, pop;

    // --------------------------------------------------
    // read requests
    // --------------------------------------------------

    assign req_o  = active_q && ((pend_q + cnt_q) < DEPTH);
    assign addr_o = base_i + {15'd0, req_cnt_q, 2'b00};
    assign rd_gnt = req_o && gnt_i;
    assign pop    = strm_valid_o && strm_ready_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            active_q  <= 1'b0;
            req_cnt_q <= '0;
            out_cnt_q <= '0;
            pend_q    <= '0;
            cnt_q     <= '0;
            wr_ptr_q  <= '0;
            rd_ptr_q  <= '0;
        end else if (clear_i) begin
            active_q  <= 1'b0;
            req_cnt_q <= '0;
            out_cnt_q <= '0;
            pend_q    <= '0;
            cnt_q     <= '0;
            wr_ptr_q  <= '0;
            rd_ptr_q  <= '0;
        end else begin
            if (go_i) begin
                active_q  <= (beats_i != '0);
                req_cnt_q <= '0;
                out_cnt_q <= '0;
            end else begin
                if (rd_gnt) begin
                    req_cnt_q <= req_cnt_q + 15'd1;
                    if (req_cnt_q == beats_i - 15'd1) active_q <= 1'b0;   // last read issued
                end
                if (pop) out_cnt_q <= out_cnt_q + 15'd1;
            end
            pend_q <= pend_q + CNT_W'(rd_gnt) - CNT_W'(rvalid_i);
            cnt_q  <= cnt_q + CNT_W'(rvalid_i) - CNT_W'(pop);
            if (rvalid_i) wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            if (pop) rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
        end
    end

    // --------------------------------------------------
    // returned word buffer and stream side
    // --------------------------------------------------

    always_ff @(posedge clk_i) begin
        if (rvalid_i) fifo_q[wr_ptr_q] <= rdata_i;
    end

    assign strm_valid_o = (cnt_q != '0);
    assign strm_data_o  = fifo_q[rd_ptr_q];
    assign strm_strb_o  = (out_cnt_q == beats_i - 15'd1) ? final_strb_i : '1;

    a_read_latency: assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i)
        rd_gnt |-> ##(`SFM_READ_LATENCY) rvalid_i);

    // the credit scheme must leave room for every returning word
    a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
        rvalid_i |-> cnt_q != CNT_W'(DEPTH));

endmodule

/* sfm_store_unit.sv */
`timescale 1ns/1ps

module sfm_store_unit (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   clear_i,
    input  logic                   go_i,
    input  sfm_pkg::sfm_addr_t     base_i,
    input  sfm_pkg::sfm_beat_cnt_t beats_i,
    input  logic                   strm_valid_i,
    input  sfm_pkg::sfm_word_t     strm_data_i,
    input  sfm_pkg::sfm_strb_t     strm_strb_i,
    input  logic                   gnt_i,
    output logic                   strm_ready_o,
    output logic                   req_o,
    output sfm_pkg::sfm_addr_t     addr_o,
    output sfm_pkg::sfm_strb_t     be_o,
    output sfm_pkg::sfm_word_t     wdata_o,
    output logic                   done_o
);

    import sfm_pkg::*;

    logic          req_q;
    logic          done_q;
    sfm_beat_cnt_t acc_cnt_q;   // beats taken from the stream
    sfm_beat_cnt_t gnt_cnt_q;   // writes committed to memory
    sfm_addr_t     addr_q;
    sfm_strb_t     be_q;
    sfm_word_t     wdata_q;
    logic          accept;
    logic          wr_gnt;

    // a new beat is taken only when the write register empties this cycle
    assign strm_ready_o = !req_q || gnt_i;
    assign accept       = strm_valid_i && strm_ready_o;
    assign wr_gnt       = req_q && gnt_i;

    // --------------------------------------------------
    // write request register
    // --------------------------------------------------

    always_ff @(posedge clk_i) begin
        if (accept) begin
            addr_q  <= base_i + {15'd0, acc_cnt_q, 2'b00};
            be_q    <= strm_strb_i;
            wdata_q <= strm_data_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            req_q     <= 1'b0;
            done_q    <= 1'b0;
            acc_cnt_q <= '0;
            gnt_cnt_q <= '0;
        end else if (clear_i) begin
            req_q     <= 1'b0;
            done_q    <= 1'b0;
            acc_cnt_q <= '0;
            gnt_cnt_q <= '0;
        end else begin
            if (accept) begin
                req_q <= 1'b1;
            end else if (wr_gnt) begin
                req_q <= 1'b0;
            end
            if (go_i) begin
                acc_cnt_q <= '0;
                gnt_cnt_q <= '0;
            end else begin
                if (accept) acc_cnt_q <= acc_cnt_q + 15'd1;
                if (wr_gnt) gnt_cnt_q <= gnt_cnt_q + 15'd1;
            end
            done_q <= wr_gnt && (gnt_cnt_q == beats_i - 15'd1);   // last write of the job
        end
    end

    assign req_o   = req_q;
    assign addr_o  = addr_q;
    assign be_o    = be_q;
    assign wdata_o = wdata_q;
    assign done_o  = done_q;

    // strobes come from the load unit and must always select some byte
    a_be_nonzero: assert property (@(posedge clk_i) disable iff (!rst_ni)
        req_o |-> be_o != '0);

endmodule

/* sfm_mem_arbiter.sv */
`timescale 1ns/1ps

module sfm_mem_arbiter (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  logic               clear_i,
    input  logic               ld_req_i,
    input  sfm_pkg::sfm_addr_t ld_addr_i,
    input  logic               st_req_i,
    input  sfm_pkg::sfm_addr_t st_addr_i,
    input  sfm_pkg::sfm_strb_t st_be_i,
    input  sfm_pkg::sfm_word_t st_wdata_i,
    input  logic               mem_gnt_i,
    input  sfm_pkg::sfm_word_t mem_rdata_i,
    input  logic               mem_rvalid_i,
    output logic               ld_gnt_o,
    output sfm_pkg::sfm_word_t ld_rdata_o,
    output logic               ld_rvalid_o,
    output logic               st_gnt_o,
    output logic               mem_req_o,
    output logic               mem_we_o,
    output sfm_pkg::sfm_addr_t mem_addr_o,
    output sfm_pkg::sfm_strb_t mem_be_o,
    output sfm_pkg::sfm_word_t mem_wdata_o
);

    import sfm_pkg::*;

    logic ptr_st_q;     // high when the store side has priority
    logic pick_st;
    logic rd_pend_q;    // a read was granted last cycle

    assign pick_st = st_req_i && (ptr_st_q || !ld_req_i);

    // --------------------------------------------------
    // request side
    // --------------------------------------------------

    assign mem_req_o   = ld_req_i || st_req_i;
    assign mem_we_o    = pick_st;
    assign mem_addr_o  = pick_st ? st_addr_i : ld_addr_i;
    assign mem_be_o    = pick_st ? st_be_i : '1;   // reads fetch the whole word
    assign mem_wdata_o = st_wdata_i;

    assign ld_gnt_o = mem_gnt_i && ld_req_i && !pick_st;
    assign st_gnt_o = mem_gnt_i && pick_st;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ptr_st_q  <= 1'b0;
            rd_pend_q <= 1'b0;
        end else if (clear_i) begin
            ptr_st_q  <= 1'b0;
            rd_pend_q <= 1'b0;
        end else begin
            // a waiting request keeps the pointer so the port stays stable
            if (mem_req_o) ptr_st_q <= mem_gnt_i ? !pick_st : pick_st;
            rd_pend_q <= ld_gnt_o;
        end
    end

    // --------------------------------------------------
    // response side
    // --------------------------------------------------

    assign ld_rdata_o  = mem_rdata_i;
    assign ld_rvalid_o = mem_rvalid_i && rd_pend_q;   // only responses to our reads

    // a request that waits for its grant keeps the port unchanged
    a_port_stable: assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i)
        mem_req_o && !mem_gnt_i |=> mem_req_o && $stable(mem_we_o) && $stable(mem_addr_o)
            && $stable(mem_be_o) && (!mem_we_o || $stable(mem_wdata_o)));

endmodule

/* sfm_streamer.sv */
`timescale 1ns/1ps

module sfm_streamer (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  logic               clear_i,
    input  logic               start_i,
    input  sfm_pkg::sfm_addr_t src_addr_i,
    input  sfm_pkg::sfm_addr_t dst_addr_i,
    input  sfm_pkg::sfm_len_t  len_i,
    input  logic               mem_gnt_i,
    input  sfm_pkg::sfm_word_t mem_rdata_i,
    input  logic               mem_rvalid_i,
    output logic               busy_o,
    output logic               done_o,
    output logic               mem_req_o,
    output logic               mem_we_o,
    output sfm_pkg::sfm_addr_t mem_addr_o,
    output sfm_pkg::sfm_strb_t mem_be_o,
    output sfm_pkg::sfm_word_t mem_wdata_o
);

    import sfm_pkg::*;

    logic          go, store_done;
    sfm_addr_t     src_base, dst_base;
    sfm_beat_cnt_t beats;
    sfm_strb_t     final_strb;

    logic          strm_valid, strm_ready;
    sfm_word_t     strm_data;
    sfm_strb_t     strm_strb;

    logic          ld_req, ld_gnt, ld_rvalid;
    sfm_addr_t     ld_addr;
    sfm_word_t     ld_rdata;
    logic          st_req, st_gnt;
    sfm_addr_t     st_addr;
    sfm_strb_t     st_be;
    sfm_word_t     st_wdata;

    sfm_job_decode i_job_decode (
        .clk_i(clk_i), .rst_ni(rst_ni), .clear_i(clear_i),
        .start_i(start_i), .src_addr_i(src_addr_i), .dst_addr_i(dst_addr_i), .len_i(len_i),
        .store_done_i(store_done), .go_o(go), .src_base_o(src_base), .dst_base_o(dst_base),
        .beats_o(beats), .final_strb_o(final_strb), .busy_o(busy_o), .done_o(done_o)
    );

    sfm_load_unit i_load_unit (
        .clk_i(clk_i), .rst_ni(rst_ni), .clear_i(clear_i),
        .go_i(go), .base_i(src_base), .beats_i(beats), .final_strb_i(final_strb),
        .gnt_i(ld_gnt), .rdata_i(ld_rdata), .rvalid_i(ld_rvalid), .strm_ready_i(strm_ready),
        .req_o(ld_req), .addr_o(ld_addr), .strm_valid_o(strm_valid),
        .strm_data_o(strm_data), .strm_strb_o(strm_strb)
    );

    sfm_store_unit i_store_unit (
        .clk_i(clk_i), .rst_ni(rst_ni), .clear_i(clear_i),
        .go_i(go), .base_i(dst_base), .beats_i(beats),
        .strm_valid_i(strm_valid), .strm_data_i(strm_data), .strm_strb_i(strm_strb),
        .gnt_i(st_gnt), .strm_ready_o(strm_ready), .req_o(st_req), .addr_o(st_addr),
        .be_o(st_be), .wdata_o(st_wdata), .done_o(store_done)
    );

    sfm_mem_arbiter i_mem_arbiter (
        .clk_i(clk_i), .rst_ni(rst_ni), .clear_i(clear_i),
        .ld_req_i(ld_req), .ld_addr_i(ld_addr),
        .st_req_i(st_req), .st_addr_i(st_addr), .st_be_i(st_be), .st_wdata_i(st_wdata),
        .mem_gnt_i(mem_gnt_i), .mem_rdata_i(mem_rdata_i), .mem_rvalid_i(mem_rvalid_i),
        .ld_gnt_o(ld_gnt), .ld_rdata_o(ld_rdata), .ld_rvalid_o(ld_rvalid), .st_gnt_o(st_gnt),
        .mem_req_o(mem_req_o), .mem_we_o(mem_we_o), .mem_addr_o(mem_addr_o),
        .mem_be_o(mem_be_o), .mem_wdata_o(mem_wdata_o)
    );

endmodule

/* tb_sfm_streamer.sv */
`timescale 1ns/1ps

module tb_sfm_streamer;

    import sfm_pkg::*;

    localparam int CLK_PERIOD = 10;
    localparam int N_RAND     = 24;
    localparam int N_JOBS     = N_RAND + 4;
    localparam int MAX_LEN    = 64;

    logic      clk_i, rst_ni, clear_i, start_i;
    sfm_addr_t src_addr_i, dst_addr_i;
    sfm_len_t  len_i;
    logic      mem_gnt_i, mem_rvalid_i;
    sfm_word_t mem_rdata_i;
    logic      busy_o, done_o, mem_req_o, mem_we_o;
    sfm_addr_t mem_addr_o;
    sfm_strb_t mem_be_o;
    sfm_word_t mem_wdata_o;

    logic [7:0] mem_q [sfm_addr_t];   // memory behind the DUT port
    logic [7:0] ref_q [sfm_addr_t];   // reference copy, updated one job at a time

    int        seed = 47;
    int        rnd;
    int        errors, jobs_run, done_cnt, starts_taken, req_cnt;
    int        rd_idx, wr_idx;
    sfm_addr_t exp_rd_base, exp_wr_base;
    logic      stall_mode = 1'b0;
    logic      grant_next;
    logic      rd_pend = 1'b0;
    sfm_word_t rd_word;
    logic      busy_due = 1'b0;
    logic      busy_prev = 1'b0;
    logic      done_prev = 1'b0;

    sfm_streamer i_sfm_streamer (.*);

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // --------------------------------------------------
    // compare tasks and memory helpers
    // --------------------------------------------------

    task automatic check_word(input string name, input sfm_word_t got, input sfm_word_t exp);
        if (got !== exp) begin
            errors++;
            $display("error %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("error %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input sfm_addr_t got, input sfm_addr_t exp);
        if (got !== exp) begin
            errors++;
            $display("error %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // untouched bytes read back a pattern built from every address bit
    function automatic logic [7:0] fill_byte(input sfm_addr_t a);
        return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h3c;
    endfunction

    function automatic logic [7:0] mem_byte(input sfm_addr_t a);
        return mem_q.exists(a) ? mem_q[a] : fill_byte(a);
    endfunction

    function automatic logic [7:0] ref_byte(input sfm_addr_t a);
        return ref_q.exists(a) ? ref_q[a] : fill_byte(a);
    endfunction

    function automatic sfm_word_t mem_word(input sfm_addr_t a);
        sfm_word_t w;
        for (int i = 0; i < 4; i++) w[8*i +: 8] = mem_byte(a + i);   // lane i is byte a+i
        return w;
    endfunction

    function automatic sfm_word_t ref_word(input sfm_addr_t a);
        sfm_word_t w;
        for (int i = 0; i < 4; i++) w[8*i +: 8] = ref_byte(a + i);
        return w;
    endfunction

    task automatic apply_model(input sfm_addr_t src, input sfm_addr_t dst, input sfm_len_t len);
        for (int i = 0; i < len; i++) ref_q[dst + i] = ref_byte(src + i);
    endtask

    // one word below the range and one past the rounded-up end are covered too
    task automatic compare_dst(input sfm_addr_t dst, input sfm_len_t len);
        sfm_addr_t stop;
        stop = dst + ((sfm_addr_t'(len) + 3) & ~sfm_addr_t'(3)) + 4;
        for (sfm_addr_t a = dst - 4; a < stop; a += 4) begin
            check_word($sformatf("memory word at %h", a), mem_word(a), ref_word(a));
        end
    endtask

    // --------------------------------------------------
    // memory model and job monitor
    // --------------------------------------------------

    always @(posedge clk_i) begin
        rnd        = $random(seed);
        grant_next = rst_ni && (!stall_mode || rnd[1:0] != 2'b00);
        #1;
        mem_rvalid_i = rd_pend;   // read data one cycle after the grant
        mem_rdata_i  = rd_word;
        rd_pend      = 1'b0;
        mem_gnt_i    = grant_next;
    end

    always @(negedge clk_i) begin
        if (rst_ni) begin
            if (mem_req_o) req_cnt++;
            if (mem_req_o && mem_gnt_i && mem_we_o) begin
                check_addr("mem_addr_o", mem_addr_o, exp_wr_base + sfm_addr_t'(4 * wr_idx));
                check_flag("mem_be_o nonzero", mem_be_o != '0, 1'b1);
                for (int i = 0; i < 4; i++) begin
                    if (mem_be_o[i]) mem_q[mem_addr_o + i] = mem_wdata_o[8*i +: 8];
                end
                wr_idx++;
            end else if (mem_req_o && mem_gnt_i) begin
                check_addr("mem_addr_o", mem_addr_o, exp_rd_base + sfm_addr_t'(4 * rd_idx));
                rd_word = mem_word(mem_addr_o);
                rd_pend = 1'b1;
                rd_idx++;
            end
        end
    end

    always @(negedge clk_i) begin
        if (rst_ni) begin
            if (busy_due) check_flag("busy_o", busy_o, 1'b1);   // cycle after a taken start
            busy_due = start_i && !busy_o;
            if (busy_due) starts_taken++;
            if (done_o) begin
                done_cnt++;
                check_flag("busy_o", busy_o, 1'b0);
                check_flag("busy_o before done_o", busy_prev, 1'b1);
                check_flag("done_o before done_o", done_prev, 1'b0);
            end
            busy_prev = busy_o;
            done_prev = done_o;
        end
    end

    // --------------------------------------------------
    // job sequence
    // --------------------------------------------------

    // called 1 ns after a rising edge and returns at the same point of the done cycle
    task automatic run_job(input sfm_addr_t src, input sfm_addr_t dst, input sfm_len_t len,
                           input logic inject);
        int        cycles;
        int        req_before;
        sfm_addr_t src_al;
        sfm_addr_t dst_al;
        src_al = src & ~sfm_addr_t'(3);
        dst_al = dst & ~sfm_addr_t'(3);
        apply_model(src_al, dst_al, len);
        exp_rd_base = src_al;
        exp_wr_base = dst_al;
        rd_idx      = 0;
        wr_idx      = 0;
        req_before  = req_cnt;
        jobs_run++;
        start_i    = 1'b1;
        src_addr_i = src;
        dst_addr_i = dst;
        len_i      = len;
        cycles     = 0;
        do begin
            @(posedge clk_i);
            #1;
            cycles++;
            start_i = inject && cycles == 3;
            if (inject && cycles == 3) begin   // a second job while busy must be dropped
                src_addr_i = 32'h0000_1300;
                len_i      = 16'd20;
            end
        end while (!done_o);
        if (len == 0) begin
            check_flag("done_o two cycles after start_i", cycles == 2, 1'b1);
            check_flag("mem_req_o during zero length job", req_cnt != req_before, 1'b0);
        end
        compare_dst(dst_al, len);
    endtask

    initial begin
        sfm_addr_t src;
        sfm_addr_t dst;
        sfm_len_t  len;
        rst_ni       = 1'b0;
        clear_i      = 1'b0;
        start_i      = 1'b0;
        src_addr_i   = '0;
        dst_addr_i   = '0;
        len_i        = '0;
        mem_gnt_i    = 1'b0;
        mem_rdata_i  = '0;
        mem_rvalid_i = 1'b0;
        repeat (2) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;
        @(posedge clk_i);
        #1;
        run_job(32'h0000_1000, 32'h0000_4000, 16'd32, 1'b0);
        stall_mode = 1'b1;
        run_job(32'h0000_1103, 32'h0000_4202, 16'd13, 1'b0);   // low bits dropped, one byte left
        run_job(32'h0000_1040, 32'h0000_4040, 16'd0, 1'b0);
        run_job(32'h0000_1200, 32'h0000_4300, 16'd48, 1'b1);
        // random jobs start in the done cycle of the one before
        for (int n = 0; n < N_RAND; n++) begin
            stall_mode = $random(seed) & 1;
            src        = 32'h0000_1000 + ($unsigned($random(seed)) % 1024);
            dst        = 32'h0000_4000 + ($unsigned($random(seed)) % 1024);
            len        = $unsigned($random(seed)) % (MAX_LEN + 1);
            run_job(src, dst, len, 1'b0);
        end
        repeat (2) @(posedge clk_i);
        if (done_cnt != jobs_run) begin
            errors++;
            $display("done_o pulsed %0d times for %0d jobs", done_cnt, jobs_run);
        end
        if (starts_taken != jobs_run) begin
            errors++;
            $display("the DUT took %0d starts for %0d jobs", starts_taken, jobs_run);
        end
        $display("errors: %0d, jobs: %0d, done pulses: %0d", errors, jobs_run, done_cnt);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin
        #(N_JOBS * MAX_LEN * 40 * CLK_PERIOD);
        $display("timeout: the DUT did not finish its jobs in the expected time");
        $display("tests failed");
        $finish;
    end

endmodule

/* project.f */
+incdir+.
sfm_pkg.sv
sfm_job_decode.sv
sfm_load_unit.sv
sfm_store_unit.sv
sfm_mem_arbiter.sv
sfm_streamer.sv
tb_sfm_streamer.sv

/* Bender.yml */
package:
  name: sfm_streamer

export_include_dirs:
  - .

sources:
  - files:
      - sfm_pkg.sv
      - sfm_job_decode.sv
      - sfm_load_unit.sv
      - sfm_store_unit.sv
      - sfm_mem_arbiter.sv
      - sfm_streamer.sv
  - target: test
    files:
      - tb_sfm_streamer.sv
